//--- all.f
source/mem_pipe_pkg.sv
source/data_sram.sv
source/mem_arbiter.sv
source/dtlb.sv
source/page_walker.sv
source/mem_lsu.sv
source/mem_pipe_top.sv
tb/tb_mem_pipe.sv

//--- run.sh
#!/bin/sh
# Build and run the data memory pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f all.f \
  --top-module tb_mem_pipe \
  --Mdir obj_dir \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0

//--- source/data_sram.sv
//**********************************************************
// Data SRAM, 1024 words with byte write enables
// and a registered read port
//**********************************************************

module data_sram
  (input                                clk_i
   , input                              en_i
   , input                              we_i
   , input mem_pipe_pkg::be_t           be_i
   , input mem_pipe_pkg::sram_addr_t    addr_i
   , input mem_pipe_pkg::word_t         wdata_i
   , output mem_pipe_pkg::word_t        rdata_o
   );

  mem_pipe_pkg::word_t mem [0:1023];

  always_ff @(posedge clk_i)
    begin
      if (en_i)
        begin
          if (we_i)
            begin
              for (int b = 0; b < 4; b++)
                begin
                  if (be_i[b])
                    mem[addr_i][8*b+:8] <= wdata_i[8*b+:8];
                end
            end
          // Read before write on the same word
          rdata_o <= mem[addr_i];
        end
    end

endmodule

//--- source/dtlb.sv
//**********************************************************
// Fully associative data TLB with combinational lookup,
// round-robin refill and flush
//**********************************************************

module dtlb
  #(parameter tlb_els_p = 4)
  (input                                clk_i
   , input                              arst_n_i

   , input mem_pipe_pkg::vpn_t          lookup_vpn_i
   , output logic                       lookup_hit_o
   , output mem_pipe_pkg::ppn_t         lookup_ppn_o
   , output logic                       lookup_writable_o

   , input                              fill_v_i
   , input mem_pipe_pkg::vpn_t          fill_vpn_i
   , input mem_pipe_pkg::ppn_t          fill_ppn_i
   , input                              fill_writable_i

   , input                              flush_i
   );

  localparam idx_width_lp = $clog2(tlb_els_p);

  logic [tlb_els_p-1:0]     v_q;
  logic [tlb_els_p-1:0]     writable_q;
  mem_pipe_pkg::vpn_t       vpn_q [tlb_els_p];
  mem_pipe_pkg::ppn_t       ppn_q [tlb_els_p];
  logic [idx_width_lp-1:0]  victim_q;

  // At most one entry matches
  always_comb
    begin
      lookup_hit_o      = 1'b0;
      lookup_ppn_o      = '0;
      lookup_writable_o = 1'b0;
      for (int i = 0; i < tlb_els_p; i++)
        begin
          if (v_q[i] && (vpn_q[i] == lookup_vpn_i))
            begin
              lookup_hit_o      = 1'b1;
              lookup_ppn_o      = ppn_q[i];
              lookup_writable_o = writable_q[i];
            end
        end
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          v_q      <= '0;
          victim_q <= '0;
        end
      else if (flush_i)
        v_q <= '0;
      else if (fill_v_i)
        begin
          v_q[victim_q] <= 1'b1;
          victim_q      <= (victim_q == idx_width_lp'(tlb_els_p - 1)) ? '0 : victim_q + 1'b1;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (fill_v_i)
        begin
          vpn_q[victim_q]      <= fill_vpn_i;
          ppn_q[victim_q]      <= fill_ppn_i;
          writable_q[victim_q] <= fill_writable_i;
        end
    end

endmodule

//--- source/mem_arbiter.sv
//**********************************************************
// SRAM port arbiter between the page walker and the LSU
// Walker has fixed priority, rvalid follows the grant owner
//**********************************************************

module mem_arbiter
  (input                                clk_i
   , input                              arst_n_i

   , input                              walker_req_i
   , input mem_pipe_pkg::sram_addr_t    walker_addr_i
   , output logic                       walker_gnt_o
   , output logic                       walker_rvalid_o

   , input                              lsu_req_i
   , input mem_pipe_pkg::sram_addr_t    lsu_addr_i
   , input                              lsu_we_i
   , input mem_pipe_pkg::be_t           lsu_be_i
   , input mem_pipe_pkg::word_t         lsu_wdata_i
   , output logic                       lsu_gnt_o
   , output logic                       lsu_rvalid_o

   , output logic                       sram_en_o
   , output mem_pipe_pkg::sram_addr_t   sram_addr_o
   , output logic                       sram_we_o
   , output mem_pipe_pkg::be_t          sram_be_o
   , output mem_pipe_pkg::word_t        sram_wdata_o
   );

  logic rd_v_q;
  logic rd_walker_q;

  assign walker_gnt_o = walker_req_i;
  assign lsu_gnt_o    = lsu_req_i & ~walker_req_i;
  assign sram_en_o    = walker_req_i | lsu_req_i;

  always_comb
    begin
      if (walker_req_i)
        begin
          // Walker only reads
          sram_addr_o  = walker_addr_i;
          sram_we_o    = 1'b0;
          sram_be_o    = '0;
          sram_wdata_o = '0;
        end
      else
        begin
          sram_addr_o  = lsu_addr_i;
          sram_we_o    = lsu_we_i;
          sram_be_o    = lsu_be_i;
          sram_wdata_o = lsu_wdata_i;
        end
    end

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          rd_v_q      <= 1'b0;
          rd_walker_q <= 1'b0;
        end
      else
        begin
          rd_v_q      <= sram_en_o;
          rd_walker_q <= walker_req_i;
        end
    end

  assign walker_rvalid_o = rd_v_q & rd_walker_q;
  assign lsu_rvalid_o    = rd_v_q & ~rd_walker_q;

endmodule

//--- source/mem_lsu.sv
//**********************************************************
// Load/store unit: address generation, alignment check,
// translation sequencing, byte lanes and response
//**********************************************************

module mem_lsu
  (input                                clk_i
   , input                              arst_n_i

   , input                              req_v_i
   , input mem_pipe_pkg::mem_op_e       req_op_i
   , input mem_pipe_pkg::word_t         req_rs1_i
   , input mem_pipe_pkg::word_t         req_imm_i
   , input mem_pipe_pkg::word_t         req_store_data_i
   , input                              trans_en_i

   , output logic                       ready_o
   , output logic                       resp_v_o
   , output mem_pipe_pkg::word_t        resp_data_o
   , output logic                       resp_misaligned_o
   , output logic                       resp_page_fault_o

   , output mem_pipe_pkg::vpn_t         lookup_vpn_o
   , input                              lookup_hit_i
   , input mem_pipe_pkg::ppn_t          lookup_ppn_i
   , input                              lookup_writable_i

   , output logic                       walk_v_o
   , output mem_pipe_pkg::vpn_t         walk_vpn_o
   , input                              walk_done_i
   , input                              walk_fault_i

   , output logic                       mem_req_o
   , output mem_pipe_pkg::sram_addr_t   mem_addr_o
   , output logic                       mem_we_o
   , output mem_pipe_pkg::be_t          mem_be_o
   , output mem_pipe_pkg::word_t        mem_wdata_o
   , input                              mem_gnt_i
   , input                              mem_rvalid_i
   , input mem_pipe_pkg::word_t         mem_rdata_i
   );

  typedef enum logic [2:0] {s_idle, s_trans, s_walk, s_access, s_wait} state_e;

  state_e                   state_q;
  logic                     mis_q;
  logic                     pf_q;
  mem_pipe_pkg::mem_op_e    op_q;
  mem_pipe_pkg::vaddr_t     vaddr_q;
  mem_pipe_pkg::word_t      sdata_q;
  logic                     trans_q;
  mem_pipe_pkg::ppn_t       ppn_q;

  mem_pipe_pkg::vaddr_t     req_vaddr;
  logic                     req_misaligned;
  logic                     accept;
  logic                     is_store;
  mem_pipe_pkg::paddr_t     paddr;
  mem_pipe_pkg::word_t      lane;
  mem_pipe_pkg::word_t      load_data;

  assign req_vaddr = mem_pipe_pkg::vaddr_t'(req_rs1_i + req_imm_i);
  assign accept    = req_v_i & ready_o;

  always_comb
    begin
      case (req_op_i)
        mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh:
          req_misaligned = req_vaddr[0];
        mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_sw:
          req_misaligned = |req_vaddr[1:0];
        default:
          req_misaligned = 1'b0;
      endcase
    end

  assign is_store = op_q inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh,
                                 mem_pipe_pkg::e_op_sw};

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        begin
          state_q <= s_idle;
          mis_q   <= 1'b0;
          pf_q    <= 1'b0;
        end
      else
        begin
          // Fault flags last one cycle
          mis_q <= 1'b0;
          pf_q  <= 1'b0;
          case (state_q)
            s_idle:
              if (accept)
                begin
                  if (req_misaligned)
                    mis_q <= 1'b1;
                  else
                    state_q <= s_trans;
                end
            s_trans:
              if (!trans_q)
                state_q <= s_access;
              else if (!lookup_hit_i)
                state_q <= s_walk;
              else if (is_store && !lookup_writable_i)
                begin
                  pf_q    <= 1'b1;
                  state_q <= s_idle;
                end
              else
                state_q <= s_access;
            s_walk:
              if (walk_done_i)
                begin
                  // Retry the lookup once the TLB is filled
                  pf_q    <= walk_fault_i;
                  state_q <= walk_fault_i ? s_idle : s_trans;
                end
            s_access:
              if (mem_gnt_i)
                state_q <= s_wait;
            s_wait:
              if (mem_rvalid_i)
                state_q <= s_idle;
            default:
              state_q <= s_idle;
          endcase
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          op_q    <= req_op_i;
          vaddr_q <= req_vaddr;
          sdata_q <= req_store_data_i;
          trans_q <= trans_en_i;
        end
      // Bare mode keeps the untranslated page bits
      if (state_q == s_trans)
        ppn_q <= trans_q ? lookup_ppn_i : vaddr_q[11:8];
    end

  assign lookup_vpn_o = vaddr_q[15:8];
  assign walk_vpn_o   = vaddr_q[15:8];
  assign walk_v_o     = (state_q == s_trans) & trans_q & ~lookup_hit_i;

  assign paddr       = {ppn_q, vaddr_q[7:0]};
  assign mem_req_o   = (state_q == s_access);
  assign mem_addr_o  = paddr[11:2];
  assign mem_we_o    = is_store;
  assign mem_wdata_o = sdata_q << {vaddr_q[1:0], 3'b000};

  always_comb
    begin
      case (op_q)
        mem_pipe_pkg::e_op_sb:
          mem_be_o = 4'b0001 << vaddr_q[1:0];
        mem_pipe_pkg::e_op_sh:
          mem_be_o = 4'b0011 << vaddr_q[1:0];
        default:
          mem_be_o = 4'b1111;
      endcase
    end

  assign lane = mem_rdata_i >> {vaddr_q[1:0], 3'b000};

  always_comb
    begin
      case (op_q)
        mem_pipe_pkg::e_op_lb:
          load_data = {{24{lane[7]}}, lane[7:0]};
        mem_pipe_pkg::e_op_lbu:
          load_data = {24'b0, lane[7:0]};
        mem_pipe_pkg::e_op_lh:
          load_data = {{16{lane[15]}}, lane[15:0]};
        mem_pipe_pkg::e_op_lhu:
          load_data = {16'b0, lane[15:0]};
        mem_pipe_pkg::e_op_lw:
          load_data = lane;
        default:
          load_data = '0;
      endcase
    end

  assign resp_v_o          = mis_q | pf_q | ((state_q == s_wait) & mem_rvalid_i);
  assign resp_data_o       = (state_q == s_wait) ? load_data : '0;
  assign resp_misaligned_o = mis_q;
  assign resp_page_fault_o = pf_q;
  assign ready_o           = (state_q == s_idle) & ~mis_q & ~pf_q;

endmodule

//--- source/mem_pipe_pkg.sv
//**********************************************************
// Shared widths, memory operation codes and the page table
// entry layout for the data memory pipe
//**********************************************************

package mem_pipe_pkg;

  typedef logic [31:0] word_t;
  typedef logic [15:0] vaddr_t;
  typedef logic [11:0] paddr_t;
  typedef logic [7:0]  vpn_t;
  typedef logic [3:0]  ppn_t;
  typedef logic [9:0]  sram_addr_t;
  typedef logic [3:0]  be_t;

  // Loads first, then stores
  typedef enum logic [2:0]
  {
    e_op_lb  = 3'd0
    , e_op_lh  = 3'd1
    , e_op_lw  = 3'd2
    , e_op_lbu = 3'd3
    , e_op_lhu = 3'd4
    , e_op_sb  = 3'd5
    , e_op_sh  = 3'd6
    , e_op_sw  = 3'd7
  } mem_op_e;

  typedef struct packed
  {
    logic [25:0] reserved;
    ppn_t        ppn;
    logic        writable;
    logic        valid;
  } pte_s;

  // One SRAM word, seen as data or as a PTE
  typedef union packed
  {
    word_t word;
    pte_s  pte;
  } pte_u;

endpackage

//--- source/mem_pipe_top.sv
//**********************************************************
// Data memory pipe top: LSU, TLB, page walker,
// SRAM arbiter and data SRAM
//**********************************************************

module mem_pipe_top
  #(parameter tlb_els_p = 4)
  (input                                clk_i
   , input                              arst_n_i

   , input                              req_v_i
   , input mem_pipe_pkg::mem_op_e       req_op_i
   , input mem_pipe_pkg::word_t         req_rs1_i
   , input mem_pipe_pkg::word_t         req_imm_i
   , input mem_pipe_pkg::word_t         req_store_data_i
   , input                              trans_en_i
   , input mem_pipe_pkg::ppn_t          pt_base_i
   , input                              sfence_i

   , output logic                       ready_o
   , output logic                       resp_v_o
   , output mem_pipe_pkg::word_t        resp_data_o
   , output logic                       resp_misaligned_o
   , output logic                       resp_page_fault_o
   );

  mem_pipe_pkg::vpn_t         lookup_vpn;
  logic                       lookup_hit, lookup_writable;
  mem_pipe_pkg::ppn_t         lookup_ppn;

  logic                       walk_v, walk_done, walk_fault;
  mem_pipe_pkg::vpn_t         walk_vpn;
  logic                       fill_v, fill_writable;
  mem_pipe_pkg::vpn_t         fill_vpn;
  mem_pipe_pkg::ppn_t         fill_ppn;

  logic                       lsu_req, lsu_we, lsu_gnt, lsu_rvalid;
  mem_pipe_pkg::sram_addr_t   lsu_addr;
  mem_pipe_pkg::be_t          lsu_be;
  mem_pipe_pkg::word_t        lsu_wdata;

  logic                       walker_req, walker_gnt, walker_rvalid;
  mem_pipe_pkg::sram_addr_t   walker_addr;

  logic                       sram_en, sram_we;
  mem_pipe_pkg::sram_addr_t   sram_addr;
  mem_pipe_pkg::be_t          sram_be;
  mem_pipe_pkg::word_t        sram_wdata, sram_rdata;

  mem_lsu
   lsu
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.req_v_i(req_v_i)
     ,.req_op_i(req_op_i)
     ,.req_rs1_i(req_rs1_i)
     ,.req_imm_i(req_imm_i)
     ,.req_store_data_i(req_store_data_i)
     ,.trans_en_i(trans_en_i)
     ,.ready_o(ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_misaligned_o(resp_misaligned_o)
     ,.resp_page_fault_o(resp_page_fault_o)
     ,.lookup_vpn_o(lookup_vpn)
     ,.lookup_hit_i(lookup_hit)
     ,.lookup_ppn_i(lookup_ppn)
     ,.lookup_writable_i(lookup_writable)
     ,.walk_v_o(walk_v)
     ,.walk_vpn_o(walk_vpn)
     ,.walk_done_i(walk_done)
     ,.walk_fault_i(walk_fault)
     ,.mem_req_o(lsu_req)
     ,.mem_addr_o(lsu_addr)
     ,.mem_we_o(lsu_we)
     ,.mem_be_o(lsu_be)
     ,.mem_wdata_o(lsu_wdata)
     ,.mem_gnt_i(lsu_gnt)
     ,.mem_rvalid_i(lsu_rvalid)
     ,.mem_rdata_i(sram_rdata)
     );

  dtlb
   #(.tlb_els_p(tlb_els_p))
   tlb
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.lookup_vpn_i(lookup_vpn)
     ,.lookup_hit_o(lookup_hit)
     ,.lookup_ppn_o(lookup_ppn)
     ,.lookup_writable_o(lookup_writable)
     ,.fill_v_i(fill_v)
     ,.fill_vpn_i(fill_vpn)
     ,.fill_ppn_i(fill_ppn)
     ,.fill_writable_i(fill_writable)
     ,.flush_i(sfence_i)
     );

  page_walker
   ptw
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.pt_base_i(pt_base_i)
     ,.walk_v_i(walk_v)
     ,.walk_vpn_i(walk_vpn)
     ,.walk_done_o(walk_done)
     ,.walk_fault_o(walk_fault)
     ,.fill_v_o(fill_v)
     ,.fill_vpn_o(fill_vpn)
     ,.fill_ppn_o(fill_ppn)
     ,.fill_writable_o(fill_writable)
     ,.mem_req_o(walker_req)
     ,.mem_addr_o(walker_addr)
     ,.mem_gnt_i(walker_gnt)
     ,.mem_rvalid_i(walker_rvalid)
     ,.mem_rdata_i(sram_rdata)
     );

  mem_arbiter
   arb
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.walker_req_i(walker_req)
     ,.walker_addr_i(walker_addr)
     ,.walker_gnt_o(walker_gnt)
     ,.walker_rvalid_o(walker_rvalid)
     ,.lsu_req_i(lsu_req)
     ,.lsu_addr_i(lsu_addr)
     ,.lsu_we_i(lsu_we)
     ,.lsu_be_i(lsu_be)
     ,.lsu_wdata_i(lsu_wdata)
     ,.lsu_gnt_o(lsu_gnt)
     ,.lsu_rvalid_o(lsu_rvalid)
     ,.sram_en_o(sram_en)
     ,.sram_addr_o(sram_addr)
     ,.sram_we_o(sram_we)
     ,.sram_be_o(sram_be)
     ,.sram_wdata_o(sram_wdata)
     );

  data_sram
   sram
    (.clk_i(clk_i)
     ,.en_i(sram_en)
     ,.we_i(sram_we)
     ,.be_i(sram_be)
     ,.addr_i(sram_addr)
     ,.wdata_i(sram_wdata)
     ,.rdata_o(sram_rdata)
     );

endmodule

//--- source/page_walker.sv
//**********************************************************
// Single level page table walker, reads one PTE from the
// SRAM and refills the TLB or reports a fault
//**********************************************************

module page_walker
  (input                                clk_i
   , input                              arst_n_i
   , input mem_pipe_pkg::ppn_t          pt_base_i

   , input                              walk_v_i
   , input mem_pipe_pkg::vpn_t          walk_vpn_i
   , output logic                       walk_done_o
   , output logic                       walk_fault_o

   , output logic                       fill_v_o
   , output mem_pipe_pkg::vpn_t         fill_vpn_o
   , output mem_pipe_pkg::ppn_t         fill_ppn_o
   , output logic                       fill_writable_o

   , output logic                       mem_req_o
   , output mem_pipe_pkg::sram_addr_t   mem_addr_o
   , input                              mem_gnt_i
   , input                              mem_rvalid_i
   , input mem_pipe_pkg::word_t         mem_rdata_i
   );

  typedef enum logic [1:0] {s_idle, s_req, s_resp} state_e;

  state_e                   state_q;
  mem_pipe_pkg::vpn_t       vpn_q;
  mem_pipe_pkg::pte_u       pte;

  assign pte.word = mem_rdata_i;

  // PTE word index is pt_base * 64 + vpn
  assign mem_req_o  = (state_q == s_req);
  assign mem_addr_o = {pt_base_i, 6'b000000} + {2'b00, vpn_q};

  assign walk_done_o     = (state_q == s_resp) & mem_rvalid_i;
  assign walk_fault_o    = walk_done_o & ~pte.pte.valid;
  assign fill_v_o        = walk_done_o & pte.pte.valid;
  assign fill_vpn_o      = vpn_q;
  assign fill_ppn_o      = pte.pte.ppn;
  assign fill_writable_o = pte.pte.writable;

  always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        state_q <= s_idle;
      else
        begin
          case (state_q)
            s_idle:
              if (walk_v_i)
                state_q <= s_req;
            s_req:
              if (mem_gnt_i)
                state_q <= s_resp;
            s_resp:
              if (mem_rvalid_i)
                state_q <= s_idle;
            default:
              state_q <= s_idle;
          endcase
        end
    end

  always_ff @(posedge clk_i)
    begin
      if ((state_q == s_idle) && walk_v_i)
        vpn_q <= walk_vpn_i;
    end

endmodule

//--- tb/tb_mem_pipe.sv
//**********************************************************
// Testbench for the data memory pipe with clock, reset,
// LFSR stimulus, reference model and response checker
//**********************************************************

module tb_mem_pipe;

  localparam int timeout_lp = 200;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    req_v_i;
  mem_pipe_pkg::mem_op_e   req_op_i;
  logic [31:0]             req_rs1_i;
  logic [31:0]             req_imm_i;
  logic [31:0]             req_store_data_i;
  logic                    trans_en_i;
  logic [3:0]              pt_base_i;
  logic                    sfence_i;
  logic                    ready_o;
  logic                    resp_v_o;
  logic [31:0]             resp_data_o;
  logic                    resp_misaligned_o;
  logic                    resp_page_fault_o;

  logic [31:0]             model_mem [0:1023];
  logic [33:0]             exp_q [$];
  logic [33:0]             resp_exp;
  logic [31:0]             lfsr_q = 32'h9d632ade;

  mem_pipe_top
   #(.tlb_els_p(4))
   DUT
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.req_v_i(req_v_i)
     ,.req_op_i(req_op_i)
     ,.req_rs1_i(req_rs1_i)
     ,.req_imm_i(req_imm_i)
     ,.req_store_data_i(req_store_data_i)
     ,.trans_en_i(trans_en_i)
     ,.pt_base_i(pt_base_i)
     ,.sfence_i(sfence_i)
     ,.ready_o(ready_o)
     ,.resp_v_o(resp_v_o)
     ,.resp_data_o(resp_data_o)
     ,.resp_misaligned_o(resp_misaligned_o)
     ,.resp_page_fault_o(resp_page_fault_o)
     );

  always #4 clk_i = ~clk_i;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      stop_with_failure($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++)
      begin
        b = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'hD0000001 : 32'h0);
        r = {r[30:0], b};
      end
    return r;
  endfunction

  function automatic logic [31:0] fill_word(input logic [9:0] idx);
    return {idx, 6'h15, ~idx, 6'h2a};
  endfunction

  function automatic logic [3:0] ppn_for(input int v);
    return 4'((v * 5 + 2) % 12);
  endfunction

  function automatic logic [15:0] align_for(input mem_pipe_pkg::mem_op_e op, input logic [15:0] a);
    case (op)
      mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh:
        return a & 16'hFFFE;
      mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_sw:
        return a & 16'hFFFC;
      default:
        return a;
    endcase
  endfunction

  // Mapped region is vpn 0 to 15; bare accesses stay off the table pages
  function automatic logic [15:0] rand_vaddr(input logic trans);
    logic [31:0] r;
    logic [3:0]  page;
    r = rand_bits(16);
    if (trans)
      return {4'h0, r[3:0], r[11:4]};
    page = r[3:0];
    if (page >= 4'd12)
      page = page - 4'd4;
    return {r[15:12], page, r[11:4]};
  endfunction

  // Returns {page fault, misaligned, data}; stores update the model memory
  function automatic logic [33:0] ref_access(input mem_pipe_pkg::mem_op_e op,
                                             input logic [15:0] va, input logic [31:0] sd,
                                             input logic trans, input logic [3:0] pt_base);
    logic        mis;
    logic        store;
    logic [11:0] pte_pa;
    logic [31:0] pte;
    logic [11:0] pa;
    logic [31:0] w;
    logic [31:0] lane;
    logic [4:0]  shamt;
    store = op inside {mem_pipe_pkg::e_op_sb, mem_pipe_pkg::e_op_sh, mem_pipe_pkg::e_op_sw};
    case (op)
      mem_pipe_pkg::e_op_lh, mem_pipe_pkg::e_op_lhu, mem_pipe_pkg::e_op_sh:
        mis = va[0];
      mem_pipe_pkg::e_op_lw, mem_pipe_pkg::e_op_sw:
        mis = (va[1:0] != 2'b00);
      default:
        mis = 1'b0;
    endcase
    if (mis)
      return {2'b01, 32'h0};
    pa = va[11:0];
    if (trans)
      begin
        // PTE byte address is pt_base * 256 + vpn * 4
        pte_pa = {pt_base, 8'h00} + {2'b00, va[15:8], 2'b00};
        pte = model_mem[pte_pa[11:2]];
        if (!pte[0] || (store && !pte[1]))
          return {2'b10, 32'h0};
        pa = {pte[5:2], va[7:0]};
      end
    w = model_mem[pa[11:2]];
    shamt = {pa[1:0], 3'b000};
    lane = w >> shamt;
    case (op)
      mem_pipe_pkg::e_op_sb: w[shamt +: 8] = sd[7:0];
      mem_pipe_pkg::e_op_sh: w[shamt +: 16] = sd[15:0];
      mem_pipe_pkg::e_op_sw: w = sd;
      default: ;
    endcase
    if (store)
      begin
        model_mem[pa[11:2]] = w;
        return {2'b00, 32'h0};
      end
    case (op)
      mem_pipe_pkg::e_op_lb: return {2'b00, {24{lane[7]}}, lane[7:0]};
      mem_pipe_pkg::e_op_lbu: return {2'b00, 24'h0, lane[7:0]};
      mem_pipe_pkg::e_op_lh: return {2'b00, {16{lane[15]}}, lane[15:0]};
      mem_pipe_pkg::e_op_lhu: return {2'b00, 16'h0, lane[15:0]};
      default: return {2'b00, lane};
    endcase
  endfunction

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready_o)
      begin
        if (n >= timeout_lp)
          stop_with_failure("Timed out waiting for ready_o to rise");
        else
          begin
            @(posedge clk_i);
            #1;
            n++;
          end
      end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() != 0)
      begin
        if (n >= timeout_lp)
          stop_with_failure("Timed out waiting for resp_v_o on an outstanding request");
        else
          begin
            @(posedge clk_i);
            #1;
            n++;
          end
      end
  endtask

  task automatic issue_req(input mem_pipe_pkg::mem_op_e op, input logic [31:0] rs1,
                           input logic [31:0] imm, input logic [31:0] sd);
    logic [31:0] sum;
    wait_ready();
    sum = rs1 + imm;
    exp_q.push_back(ref_access(op, sum[15:0], sd, trans_en_i, pt_base_i));
    req_v_i = 1'b1;
    req_op_i = op;
    req_rs1_i = rs1;
    req_imm_i = imm;
    req_store_data_i = sd;
    @(posedge clk_i);
    #1;
    req_v_i = 1'b0;
    // Busy from the cycle after acceptance
    check_value("ready_o", {31'h0, ready_o}, 32'h0);
  endtask

  task automatic pulse_sfence();
    wait_ready();
    sfence_i = 1'b1;
    @(posedge clk_i);
    #1;
    sfence_i = 1'b0;
  endtask

  // Bare store of one PTE with random reserved bits
  task automatic write_pte(input logic [7:0] vpn, input logic [3:0] ppn, input logic wr,
                           input logic valid);
    logic [31:0] r;
    r = rand_bits(26);
    trans_en_i = 1'b0;
    issue_req(mem_pipe_pkg::e_op_sw, {20'h0, pt_base_i, 8'h00}, {22'h0, vpn, 2'b00},
              {r[25:0], ppn, wr, valid});
  endtask

  task automatic random_access(input logic aligned);
    mem_pipe_pkg::mem_op_e op;
    logic [15:0]           va;
    logic [31:0]           r;
    logic [31:0]           imm;
    logic [31:0]           hi;
    r = rand_bits(3);
    op = mem_pipe_pkg::mem_op_e'(r[2:0]);
    va = rand_vaddr(trans_en_i);
    if (aligned)
      va = align_for(op, va);
    r = rand_bits(12);
    imm = {{20{r[11]}}, r[11:0]};
    hi = rand_bits(16);
    issue_req(op, {hi[15:0], va} - imm, imm, rand_bits(32));
  endtask

  // Response checker
  always @(negedge clk_i)
    begin
      if (arst_n_i && resp_v_o)
        begin
          if (exp_q.size() == 0)
            stop_with_failure("Response seen with no request outstanding");
          else
            begin
              resp_exp = exp_q.pop_front();
              check_value("resp_data_o", resp_data_o, resp_exp[31:0]);
              check_value("resp_misaligned_o", {31'h0, resp_misaligned_o}, {31'h0, resp_exp[32]});
              check_value("resp_page_fault_o", {31'h0, resp_page_fault_o}, {31'h0, resp_exp[33]});
            end
        end
    end

  initial
    begin
      clk_i = 1'b0;
      arst_n_i = 1'b0;
      req_v_i = 1'b0;
      req_op_i = mem_pipe_pkg::e_op_lw;
      req_rs1_i = '0;
      req_imm_i = '0;
      req_store_data_i = '0;
      trans_en_i = 1'b0;
      pt_base_i = 4'hC;
      sfence_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      check_value("resp_v_o", {31'h0, resp_v_o}, 32'h0);
      check_value("resp_misaligned_o", {31'h0, resp_misaligned_o}, 32'h0);
      check_value("resp_page_fault_o", {31'h0, resp_page_fault_o}, 32'h0);
      wait_ready();

      // Known contents in every word
      for (int i = 0; i < 1024; i++)
        issue_req(mem_pipe_pkg::e_op_sw, 32'(i * 4) + 32'h0001_0000, 32'h0, fill_word(10'(i)));
      repeat (400) random_access(1'b1);

      // Vpn 0..7 mapped with vpn 3 read only, vpn 8..15 invalid
      for (int v = 0; v < 16; v++)
        write_pte(8'(v), ppn_for(v), v != 3, v < 8);
      pulse_sfence();
      trans_en_i = 1'b1;
      repeat (400) random_access(1'b1);

      issue_req(mem_pipe_pkg::e_op_sw, 32'h0000_0340, 32'h0, 32'hDEAD_BEEF);
      issue_req(mem_pipe_pkg::e_op_lw, 32'h0000_0920, 32'h0, 32'h0);
      issue_req(mem_pipe_pkg::e_op_sb, 32'h0000_0C10, 32'h0, 32'h0000_0055);
      trans_en_i = 1'b0;
      issue_req(mem_pipe_pkg::e_op_lw, {20'h0, ppn_for(3), 8'h40}, 32'h0, 32'h0);
      issue_req(mem_pipe_pkg::e_op_lw, {20'h0, ppn_for(12), 8'h10}, 32'h0, 32'h0);

      // Unaligned mix in both modes
      trans_en_i = 1'b1;
      repeat (150) random_access(1'b0);
      trans_en_i = 1'b0;
      repeat (150) random_access(1'b0);

      // Remap vpn 2 while it sits in the TLB
      trans_en_i = 1'b1;
      issue_req(mem_pipe_pkg::e_op_lw, 32'h0000_0200, 32'h0, 32'h0);
      write_pte(8'h02, 4'd11, 1'b1, 1'b1);
      pulse_sfence();
      trans_en_i = 1'b1;
      issue_req(mem_pipe_pkg::e_op_sw, 32'h0000_0280, 32'h4, 32'hC0DE_1234);
      issue_req(mem_pipe_pkg::e_op_lw, 32'h0000_0284, 32'h0, 32'h0);
      repeat (100) random_access(1'b1);
      trans_en_i = 1'b0;
      issue_req(mem_pipe_pkg::e_op_lw, 32'h0000_0B84, 32'h0, 32'h0);

      wait_drained();
      $display("Done: no errors");
      $finish;
    end

endmodule
